/* wbb_defines.svh */
`ifndef WBB_DEFINES_SVH
`define WBB_DEFINES_SVH

// --------------------
// Bus widths
// --------------------

// Byte address width
`define WBB_AW 32

// Data width
`define WBB_DW 32

// One select bit per byte lane
`define WBB_BW 4

// Burst count width, a count of 1 is one word
`define WBB_BL 10

// --------------------
// Storage sizes
// --------------------

// Entries in each bridge FIFO
`define WBB_FIFO_DP 4

// Word address width of the target, 256 words
`define WBB_MEM_AW 8

`endif

/* wbb_pkg.sv */
`default_nettype none

`include "wbb_defines.svh"

package wbb_pkg;

  // Master controller states
  typedef enum logic [1:0] {
    M_IDLE  = 2'b00,
    M_WRITE = 2'b01,
    M_READ  = 2'b10
  } m_state_e;

  // Memory target states
  typedef enum logic {
    MEM_IDLE  = 1'b0,
    MEM_BURST = 1'b1
  } mem_state_e;

  // Command entry is {adr, we, dat, sel, bl}
  localparam int CMD_W = `WBB_AW + 1 + `WBB_DW + `WBB_BW + `WBB_BL;

  // Response entry is {last, dat}
  localparam int RSP_W = `WBB_DW + 1;

endpackage

`default_nettype wire

/* wbb_sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wbb_defines.svh"

module wbb_sync_fifo #(
  parameter int W = 8
) (
  input  logic         clk_i,
  input  logic         rst_n,
  input  logic         wr_en_i,
  input  logic [W-1:0] wr_data_i,
  input  logic         rd_en_i,
  output logic         full_o,
  output logic         afull_o,
  output logic         empty_o,
  output logic         aempty_o,
  output logic [W-1:0] rd_data_o
);

  localparam int PW = $clog2(`WBB_FIFO_DP);
  localparam logic [PW:0]   CNT_FULL = (PW+1)'(`WBB_FIFO_DP);
  localparam logic [PW:0]   CNT_ONE  = (PW+1)'(1);
  localparam logic [PW-1:0] PTR_LAST = PW'(`WBB_FIFO_DP - 1);

  logic [W-1:0]  mem [`WBB_FIFO_DP];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          do_wr;
  logic          do_rd;

  // Overflow and underflow requests are dropped
  assign do_wr = wr_en_i && !full_o;
  assign do_rd = rd_en_i && !empty_o;

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // Head word shows without a read request
  assign rd_data_o = mem[rd_ptr];

  // Status flags
  assign full_o   = (count == CNT_FULL);
  assign afull_o  = (count == CNT_FULL - CNT_ONE);
  assign empty_o  = (count == '0);
  assign aempty_o = (count == CNT_ONE);

endmodule

`default_nettype wire

/* wbb_master_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wbb_defines.svh"

module wbb_master_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  logic                      wbm_stb_i,
  input  logic                      wbm_we_i,
  input  logic [`WBB_AW-1:0]        wbm_adr_i,
  input  logic [`WBB_DW-1:0]        wbm_dat_i,
  input  logic [`WBB_BW-1:0]        wbm_sel_i,
  input  logic [`WBB_BL-1:0]        wbm_bl_i,
  input  logic                      wbm_bry_i,
  input  logic                      cmd_full_i,
  input  logic                      rsp_empty_i,
  input  logic                      rsp_aempty_i,
  input  logic [wbb_pkg::RSP_W-1:0] rsp_data_i,
  output logic                      cmd_wr_en_o,
  output logic [wbb_pkg::CMD_W-1:0] cmd_wr_data_o,
  output logic                      rsp_rd_en_o,
  output logic [`WBB_DW-1:0]        wbm_dat_o,
  output logic                      wbm_ack_o,
  output logic                      wbm_lack_o
);

  localparam logic [`WBB_BL-1:0] ONE_BEAT = `WBB_BL'(1);

  wbb_pkg::m_state_e  state;
  logic [`WBB_BL-1:0] bl_cnt;
  logic               rd_ready;

  // Command entry taken straight off the master bus
  // Written on the edge that closes the ack cycle
  assign cmd_wr_data_o = {wbm_adr_i, wbm_we_i, wbm_dat_i, wbm_sel_i, wbm_bl_i};

  // Read data is the response head
  assign wbm_dat_o = rsp_data_i[`WBB_DW-1:0];

  // Back to back read ack
  // A pop already pending needs a second entry behind it
  assign rd_ready = wbm_bry_i && !rsp_empty_i && !(wbm_ack_o && rsp_aempty_i);

  // --------------------
  // Master FSM
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state       <= wbb_pkg::M_IDLE;
      bl_cnt      <= '0;
      cmd_wr_en_o <= 1'b0;
      rsp_rd_en_o <= 1'b0;
      wbm_ack_o   <= 1'b0;
      wbm_lack_o  <= 1'b0;
    end else begin
      // Single cycle pulses by default
      cmd_wr_en_o <= 1'b0;
      rsp_rd_en_o <= 1'b0;
      wbm_ack_o   <= 1'b0;
      wbm_lack_o  <= 1'b0;
      case (state)
        wbb_pkg::M_IDLE: begin
          // stb may still be high in the lack cycle
          if (wbm_stb_i && wbm_bry_i && !cmd_full_i && !wbm_lack_o) begin
            cmd_wr_en_o <= 1'b1;
            if (!wbm_we_i) begin
              // One command entry for the whole read
              bl_cnt <= wbm_bl_i;
              state  <= wbb_pkg::M_READ;
            end else begin
              wbm_ack_o <= 1'b1;
              bl_cnt    <= wbm_bl_i - 1'b1;
              if (wbm_bl_i == ONE_BEAT) begin
                wbm_lack_o <= 1'b1;
              end else begin
                state <= wbb_pkg::M_WRITE;
              end
            end
          end
        end
        wbb_pkg::M_WRITE: begin
          // Skip the ack cycle so the pending push is counted in full
          if (!wbm_ack_o && wbm_bry_i && !cmd_full_i) begin
            cmd_wr_en_o <= 1'b1;
            wbm_ack_o   <= 1'b1;
            if (bl_cnt == ONE_BEAT) begin
              wbm_lack_o <= 1'b1;
              state      <= wbb_pkg::M_IDLE;
            end else begin
              bl_cnt <= bl_cnt - 1'b1;
            end
          end
        end
        wbb_pkg::M_READ: begin
          // One response entry per ack
          if (rd_ready) begin
            rsp_rd_en_o <= 1'b1;
            wbm_ack_o   <= 1'b1;
            if (bl_cnt == ONE_BEAT) begin
              wbm_lack_o <= 1'b1;
              state      <= wbb_pkg::M_IDLE;
            end else begin
              bl_cnt <= bl_cnt - 1'b1;
            end
          end
        end
        default: begin
          state <= wbb_pkg::M_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* wbb_slave_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wbb_defines.svh"

module wbb_slave_seq (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  logic                      cmd_empty_i,
  input  logic                      cmd_aempty_i,
  input  logic [wbb_pkg::CMD_W-1:0] cmd_data_i,
  input  logic                      rsp_full_i,
  input  logic                      rsp_afull_i,
  input  logic [`WBB_DW-1:0]        wbs_dat_i,
  input  logic                      wbs_ack_i,
  input  logic                      wbs_lack_i,
  output logic                      cmd_rd_en_o,
  output logic                      rsp_wr_en_o,
  output logic [wbb_pkg::RSP_W-1:0] rsp_wr_data_o,
  output logic                      wbs_cyc_o,
  output logic                      wbs_stb_o,
  output logic                      wbs_we_o,
  output logic [`WBB_AW-1:0]        wbs_adr_o,
  output logic [`WBB_DW-1:0]        wbs_dat_o,
  output logic [`WBB_BW-1:0]        wbs_sel_o,
  output logic [`WBB_BL-1:0]        wbs_bl_o,
  output logic                      wbs_bry_o
);

  localparam logic [`WBB_BL-1:0] ONE_BEAT = `WBB_BL'(1);

  logic [wbb_pkg::CMD_W-1:0] cmd_held;
  logic [wbb_pkg::CMD_W-1:0] cmd_cur;
  logic                      stb_d;
  logic                      lack_d;
  logic                      burst;
  logic                      stb_rise;

  // --------------------
  // Slave bus request
  // --------------------

  // Held copy covers a write burst whose FIFO ran dry
  assign cmd_cur = cmd_empty_i ? cmd_held : cmd_data_i;
  assign {wbs_adr_o, wbs_we_o, wbs_dat_o, wbs_sel_o, wbs_bl_o} = cmd_cur;

  // Forced low for one cycle after lack
  assign wbs_stb_o = burst || (!lack_d && !cmd_empty_i);
  assign wbs_cyc_o = wbs_stb_o;
  assign stb_rise  = wbs_stb_o && !stb_d;

  // Write needs a data entry left after any pending pop
  // Read needs response space left after any pending push
  assign wbs_bry_o = wbs_we_o ? !(cmd_empty_i || (cmd_rd_en_o && cmd_aempty_i)) :
                                !(rsp_full_i || (rsp_wr_en_o && rsp_afull_i));

  // Write pops per ack, read holds its single entry until lack
  assign cmd_rd_en_o = (wbs_stb_o && wbs_we_o) ? wbs_ack_i : wbs_lack_i;

  // Responses only for reads
  assign rsp_wr_en_o   = wbs_stb_o && !wbs_we_o && wbs_ack_i;
  assign rsp_wr_data_o = {wbs_lack_i, wbs_dat_i};

  // Burst tracking
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      cmd_held <= '0;
      stb_d    <= 1'b0;
      lack_d   <= 1'b0;
      burst    <= 1'b0;
    end else begin
      stb_d  <= wbs_stb_o;
      lack_d <= wbs_lack_i;
      if (cmd_rd_en_o && !cmd_empty_i) begin
        cmd_held <= cmd_data_i;
      end
      // Single beats need no burst hold
      if (stb_rise && (wbs_bl_o > ONE_BEAT)) begin
        burst <= 1'b1;
      end else if (wbs_lack_i) begin
        burst <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* wbb_burst_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wbb_defines.svh"

module wbb_burst_bridge (
  input  logic               clk_i,
  input  logic               rst_n,
  // Master bus
  input  logic               wbm_cyc_i,
  input  logic               wbm_stb_i,
  input  logic               wbm_we_i,
  input  logic [`WBB_AW-1:0] wbm_adr_i,
  input  logic [`WBB_DW-1:0] wbm_dat_i,
  input  logic [`WBB_BW-1:0] wbm_sel_i,
  input  logic [`WBB_BL-1:0] wbm_bl_i,
  input  logic               wbm_bry_i,
  output logic [`WBB_DW-1:0] wbm_dat_o,
  output logic               wbm_ack_o,
  output logic               wbm_lack_o,
  // Slave bus
  output logic               wbs_cyc_o,
  output logic               wbs_stb_o,
  output logic               wbs_we_o,
  output logic [`WBB_AW-1:0] wbs_adr_o,
  output logic [`WBB_DW-1:0] wbs_dat_o,
  output logic [`WBB_BW-1:0] wbs_sel_o,
  output logic [`WBB_BL-1:0] wbs_bl_o,
  output logic               wbs_bry_o,
  input  logic [`WBB_DW-1:0] wbs_dat_i,
  input  logic               wbs_ack_i,
  input  logic               wbs_lack_i
);

  // Command path
  logic                      cmd_wr_en;
  logic [wbb_pkg::CMD_W-1:0] cmd_wr_data;
  logic                      cmd_full;
  logic                      cmd_rd_en;
  logic                      cmd_empty;
  logic                      cmd_aempty;
  logic [wbb_pkg::CMD_W-1:0] cmd_rd_data;

  // Response path
  logic                      rsp_wr_en;
  logic [wbb_pkg::RSP_W-1:0] rsp_wr_data;
  logic                      rsp_full;
  logic                      rsp_afull;
  logic                      rsp_rd_en;
  logic                      rsp_empty;
  logic                      rsp_aempty;
  logic [wbb_pkg::RSP_W-1:0] rsp_rd_data;

  // stb only counts inside a cycle
  logic                      m_stb;

  assign m_stb = wbm_cyc_i && wbm_stb_i;

  wbb_master_ctrl u_master_ctrl (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .wbm_stb_i     (m_stb),
    .wbm_we_i      (wbm_we_i),
    .wbm_adr_i     (wbm_adr_i),
    .wbm_dat_i     (wbm_dat_i),
    .wbm_sel_i     (wbm_sel_i),
    .wbm_bl_i      (wbm_bl_i),
    .wbm_bry_i     (wbm_bry_i),
    .cmd_full_i    (cmd_full),
    .rsp_empty_i   (rsp_empty),
    .rsp_aempty_i  (rsp_aempty),
    .rsp_data_i    (rsp_rd_data),
    .cmd_wr_en_o   (cmd_wr_en),
    .cmd_wr_data_o (cmd_wr_data),
    .rsp_rd_en_o   (rsp_rd_en),
    .wbm_dat_o     (wbm_dat_o),
    .wbm_ack_o     (wbm_ack_o),
    .wbm_lack_o    (wbm_lack_o)
  );

  // Write beats and read commands
  wbb_sync_fifo #(.W(wbb_pkg::CMD_W)) u_cmd_fifo (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .wr_en_i   (cmd_wr_en),
    .wr_data_i (cmd_wr_data),
    .rd_en_i   (cmd_rd_en),
    .full_o    (cmd_full),
    .afull_o   (),
    .empty_o   (cmd_empty),
    .aempty_o  (cmd_aempty),
    .rd_data_o (cmd_rd_data)
  );

  // Read data only
  wbb_sync_fifo #(.W(wbb_pkg::RSP_W)) u_rsp_fifo (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .wr_en_i   (rsp_wr_en),
    .wr_data_i (rsp_wr_data),
    .rd_en_i   (rsp_rd_en),
    .full_o    (rsp_full),
    .afull_o   (rsp_afull),
    .empty_o   (rsp_empty),
    .aempty_o  (rsp_aempty),
    .rd_data_o (rsp_rd_data)
  );

  wbb_slave_seq u_slave_seq (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .cmd_empty_i   (cmd_empty),
    .cmd_aempty_i  (cmd_aempty),
    .cmd_data_i    (cmd_rd_data),
    .rsp_full_i    (rsp_full),
    .rsp_afull_i   (rsp_afull),
    .wbs_dat_i     (wbs_dat_i),
    .wbs_ack_i     (wbs_ack_i),
    .wbs_lack_i    (wbs_lack_i),
    .cmd_rd_en_o   (cmd_rd_en),
    .rsp_wr_en_o   (rsp_wr_en),
    .rsp_wr_data_o (rsp_wr_data),
    .wbs_cyc_o     (wbs_cyc_o),
    .wbs_stb_o     (wbs_stb_o),
    .wbs_we_o      (wbs_we_o),
    .wbs_adr_o     (wbs_adr_o),
    .wbs_dat_o     (wbs_dat_o),
    .wbs_sel_o     (wbs_sel_o),
    .wbs_bl_o      (wbs_bl_o),
    .wbs_bry_o     (wbs_bry_o)
  );

endmodule

`default_nettype wire

/* wbb_burst_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wbb_defines.svh"

module wbb_burst_mem (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               wbs_cyc_i,
  input  logic               wbs_stb_i,
  input  logic               wbs_we_i,
  input  logic [`WBB_AW-1:0] wbs_adr_i,
  input  logic [`WBB_DW-1:0] wbs_dat_i,
  input  logic [`WBB_BW-1:0] wbs_sel_i,
  input  logic [`WBB_BL-1:0] wbs_bl_i,
  input  logic               wbs_bry_i,
  output logic [`WBB_DW-1:0] wbs_dat_o,
  output logic               wbs_ack_o,
  output logic               wbs_lack_o
);

  localparam int DEPTH = 1 << `WBB_MEM_AW;
  localparam logic [`WBB_BL-1:0] ONE_BEAT = `WBB_BL'(1);

  logic [`WBB_DW-1:0]     mem [DEPTH];
  wbb_pkg::mem_state_e    state;
  logic [`WBB_MEM_AW-1:0] cur_adr;
  logic [`WBB_MEM_AW-1:0] ack_adr;
  logic [`WBB_BL-1:0]     remain;
  logic [`WBB_MEM_AW-1:0] beat_adr;
  logic [`WBB_BL-1:0]     beat_rem;
  logic                   beat;
  logic                   idle;

  assign idle = (state == wbb_pkg::MEM_IDLE);

  // First beat takes word address and count from the bus
  assign beat_adr = idle ? wbs_adr_i[`WBB_MEM_AW+1:2] : cur_adr;
  assign beat_rem = idle ? wbs_bl_i : remain;

  // No restart while stb lingers in the lack cycle
  assign beat = wbs_cyc_i && wbs_stb_i && wbs_bry_i && !(idle && wbs_lack_o);

  // --------------------
  // Beat control
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state      <= wbb_pkg::MEM_IDLE;
      cur_adr    <= '0;
      remain     <= '0;
      wbs_ack_o  <= 1'b0;
      wbs_lack_o <= 1'b0;
    end else begin
      wbs_ack_o  <= beat;
      wbs_lack_o <= beat && (beat_rem == ONE_BEAT);
      if (beat) begin
        // Word address wraps at the top of the array
        cur_adr <= beat_adr + 1'b1;
        remain  <= beat_rem - 1'b1;
        state   <= (beat_rem == ONE_BEAT) ? wbb_pkg::MEM_IDLE : wbb_pkg::MEM_BURST;
      end
    end
  end

  // --------------------
  // Data array
  // --------------------
  always_ff @(posedge clk_i) begin
    if (beat) begin
      ack_adr <= beat_adr;
      if (!wbs_we_i) begin
        wbs_dat_o <= mem[beat_adr];
      end
    end
    // Write data is the command head during the ack cycle
    if (wbs_ack_o && wbs_we_i) begin
      for (int b = 0; b < `WBB_BW; b++) begin
        if (wbs_sel_i[b]) begin
          mem[ack_adr][8*b +: 8] <= wbs_dat_i[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* wbb_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wbb_defines.svh"

module wbb_subsys_top (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               wbm_cyc_i,
  input  logic               wbm_stb_i,
  input  logic               wbm_we_i,
  input  logic [`WBB_AW-1:0] wbm_adr_i,
  input  logic [`WBB_DW-1:0] wbm_dat_i,
  input  logic [`WBB_BW-1:0] wbm_sel_i,
  input  logic [`WBB_BL-1:0] wbm_bl_i,
  input  logic               wbm_bry_i,
  output logic [`WBB_DW-1:0] wbm_dat_o,
  output logic               wbm_ack_o,
  output logic               wbm_lack_o
);

  // Slave bus between bridge and memory
  logic               wbs_cyc;
  logic               wbs_stb;
  logic               wbs_we;
  logic [`WBB_AW-1:0] wbs_adr;
  logic [`WBB_DW-1:0] wbs_wdat;
  logic [`WBB_BW-1:0] wbs_sel;
  logic [`WBB_BL-1:0] wbs_bl;
  logic               wbs_bry;
  logic [`WBB_DW-1:0] wbs_rdat;
  logic               wbs_ack;
  logic               wbs_lack;

  wbb_burst_bridge u_bridge (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .wbm_cyc_i  (wbm_cyc_i),
    .wbm_stb_i  (wbm_stb_i),
    .wbm_we_i   (wbm_we_i),
    .wbm_adr_i  (wbm_adr_i),
    .wbm_dat_i  (wbm_dat_i),
    .wbm_sel_i  (wbm_sel_i),
    .wbm_bl_i   (wbm_bl_i),
    .wbm_bry_i  (wbm_bry_i),
    .wbm_dat_o  (wbm_dat_o),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_lack_o (wbm_lack_o),
    .wbs_cyc_o  (wbs_cyc),
    .wbs_stb_o  (wbs_stb),
    .wbs_we_o   (wbs_we),
    .wbs_adr_o  (wbs_adr),
    .wbs_dat_o  (wbs_wdat),
    .wbs_sel_o  (wbs_sel),
    .wbs_bl_o   (wbs_bl),
    .wbs_bry_o  (wbs_bry),
    .wbs_dat_i  (wbs_rdat),
    .wbs_ack_i  (wbs_ack),
    .wbs_lack_i (wbs_lack)
  );

  wbb_burst_mem u_mem (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .wbs_cyc_i  (wbs_cyc),
    .wbs_stb_i  (wbs_stb),
    .wbs_we_i   (wbs_we),
    .wbs_adr_i  (wbs_adr),
    .wbs_dat_i  (wbs_wdat),
    .wbs_sel_i  (wbs_sel),
    .wbs_bl_i   (wbs_bl),
    .wbs_bry_i  (wbs_bry),
    .wbs_dat_o  (wbs_rdat),
    .wbs_ack_o  (wbs_ack),
    .wbs_lack_o (wbs_lack)
  );

endmodule

`default_nettype wire

/* tb_wbb_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wbb_defines.svh"

module tb_wbb_subsys;

  localparam int CLK_PERIOD = 10;
  localparam int MEM_WORDS  = 1 << `WBB_MEM_AW;
  localparam int MAX_BL     = MEM_WORDS;
  localparam int NUM_RUNS   = 4;
  // Fill, single beat, then three groups of write plus read at up to 16 beats
  localparam int TOTAL_BEATS     = MEM_WORDS + 2 + 3 * NUM_RUNS * 2 * 16;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 1000;

  logic               clk_i;
  logic               rst_n;
  logic               wbm_cyc_i;
  logic               wbm_stb_i;
  logic               wbm_we_i;
  logic [`WBB_AW-1:0] wbm_adr_i;
  logic [`WBB_DW-1:0] wbm_dat_i;
  logic [`WBB_BW-1:0] wbm_sel_i;
  logic [`WBB_BL-1:0] wbm_bl_i;
  logic               wbm_bry_i;
  logic [`WBB_DW-1:0] wbm_dat_o;
  logic               wbm_ack_o;
  logic               wbm_lack_o;

  // Byte-wise model of the target indexed by {word, lane}
  logic [7:0]         shadow [MEM_WORDS*4];
  // Beats of the next write burst
  logic [31:0]        wdat [MAX_BL];
  logic [3:0]         wsel [MAX_BL];
  logic [31:0]        lfsr_q;
  logic               bry_random;
  logic               stb_seen;
  int                 seq_errors;
  int                 lack_errors;
  int                 bry_errors;
  int                 idle_errors;
  int                 stray_errors;
  int                 tests_run;
  int                 tests_failed;
  int                 errs_before;

  wbb_subsys_top dut0 (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .wbm_cyc_i  (wbm_cyc_i),
    .wbm_stb_i  (wbm_stb_i),
    .wbm_we_i   (wbm_we_i),
    .wbm_adr_i  (wbm_adr_i),
    .wbm_dat_i  (wbm_dat_i),
    .wbm_sel_i  (wbm_sel_i),
    .wbm_bl_i   (wbm_bl_i),
    .wbm_bry_i  (wbm_bry_i),
    .wbm_dat_o  (wbm_dat_o),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_lack_o (wbm_lack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Bus rules
  // --------------------

  // lack only together with ack
  assert property (@(posedge clk_i) disable iff (!rst_n) wbm_lack_o |-> wbm_ack_o)
    else begin
      lack_errors++;
      $display("CHECK FAILED at %0t: wbm_ack_o expected 1, got %b",
               $time, $sampled(wbm_ack_o));
    end

  // Every ack was granted by bry at the edge before
  assert property (@(posedge clk_i) disable iff (!rst_n) wbm_ack_o |-> $past(wbm_bry_i))
    else begin
      bry_errors++;
      $display("CHECK FAILED at %0t: wbm_bry_i expected 1, got 0", $time);
    end

  // No ack outside a burst or in the cycle after its lack
  assert property (@(posedge clk_i) disable iff (!rst_n)
                   wbm_ack_o |-> ($past(wbm_stb_i) && !$past(wbm_lack_o)))
    else begin
      stray_errors++;
      $display("CHECK FAILED at %0t: wbm_ack_o expected 0, got 1", $time);
    end

  // Quiet master bus from reset until the first stb
  assert property (@(posedge clk_i) disable iff (!rst_n)
                   !stb_seen |-> (!wbm_ack_o && !wbm_lack_o))
    else begin
      idle_errors++;
      $display("CHECK FAILED at %0t: wbm_ack_o/wbm_lack_o expected 0/0, got %b/%b",
               $time, $sampled(wbm_ack_o), $sampled(wbm_lack_o));
    end

  // --------------------
  // Helpers
  // --------------------

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Ready about three cycles in four under back-pressure
  function automatic logic next_bry();
    logic [31:0] r;
    if (!bry_random) begin
      return 1'b1;
    end
    r = rand_bits(2);
    return (r[1:0] != 2'b00);
  endfunction

  // Initial contents with every address bit in the word
  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h3c, ~a, a, a + 8'h81};
  endfunction

  function automatic logic [31:0] shadow_word(input logic [7:0] w);
    return {shadow[{w, 2'd3}], shadow[{w, 2'd2}], shadow[{w, 2'd1}], shadow[{w, 2'd0}]};
  endfunction

  function automatic int total_errors();
    return seq_errors + lack_errors + bry_errors + idle_errors + stray_errors;
  endfunction

  task automatic report_test(input string name);
    tests_run++;
    if (total_errors() != errs_before) begin
      tests_failed++;
      $display("test %-14s FAILED (%0d errors)", name, total_errors() - errs_before);
    end else begin
      $display("test %-14s ok", name);
    end
    errs_before = total_errors();
  endtask

  // One master burst with beats counted until lack
  task automatic run_burst(input logic we, input logic [7:0] word, input int bl);
    int          k;
    logic        done;
    logic        got_ack;
    logic        got_lack;
    logic [31:0] got_dat;
    logic [31:0] exp_dat;
    logic [7:0]  w;
    k    = 0;
    done = 1'b0;
    @(posedge clk_i);
    #1;
    stb_seen  = 1'b1;
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;
    wbm_we_i  = we;
    wbm_adr_i = {{(`WBB_AW-10){1'b0}}, word, 2'b00};
    wbm_bl_i  = bl[`WBB_BL-1:0];
    wbm_dat_i = wdat[0];
    wbm_sel_i = wsel[0];
    wbm_bry_i = next_bry();
    while (!done) begin
      // Mid-cycle sample of the ack cycle
      @(negedge clk_i);
      got_ack  = wbm_ack_o;
      got_lack = wbm_lack_o;
      got_dat  = wbm_dat_o;
      @(posedge clk_i);
      #1;
      if (got_ack) begin
        w = word + k[7:0];
        if (we) begin
          for (int b = 0; b < 4; b++) begin
            if (wsel[k][b]) begin
              shadow[{w, b[1:0]}] = wdat[k][8*b +: 8];
            end
          end
        end else begin
          exp_dat = shadow_word(w);
          assert (got_dat == exp_dat)
            else begin
              seq_errors++;
              $display("CHECK FAILED at %0t: wbm_dat_o expected %h, got %h",
                       $time, exp_dat, got_dat);
            end
        end
        // lack on the last beat and nowhere else
        assert (got_lack == (k == bl - 1))
          else begin
            seq_errors++;
            $display("CHECK FAILED at %0t: wbm_lack_o expected %b, got %b",
                     $time, (k == bl - 1), got_lack);
          end
        k++;
        done = got_lack || (k == bl);
        if (!done) begin
          wbm_dat_i = wdat[k];
          wbm_sel_i = wsel[k];
        end
      end
      if (!done) begin
        wbm_bry_i = next_bry();
      end
    end
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
    wbm_bry_i = 1'b0;
  endtask

  // Random burst of 2 to 16 beats and its read back
  task automatic write_read(input logic partial);
    logic [31:0] r;
    logic [7:0]  word;
    int          bl;
    r    = rand_bits(8);
    word = r[7:0];
    r    = rand_bits(4);
    bl   = 2 + int'(r % 32'd15);
    for (int i = 0; i < bl; i++) begin
      wdat[i] = rand_bits(32);
      r       = rand_bits(4);
      wsel[i] = partial ? r[3:0] : 4'hf;
    end
    run_burst(1'b1, word, bl);
    run_burst(1'b0, word, bl);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] r;
    rst_n        = 1'b0;
    wbm_cyc_i    = 1'b0;
    wbm_stb_i    = 1'b0;
    wbm_we_i     = 1'b0;
    wbm_adr_i    = '0;
    wbm_dat_i    = '0;
    wbm_sel_i    = '0;
    wbm_bl_i     = '0;
    wbm_bry_i    = 1'b0;
    lfsr_q       = 32'he359_dd9e;
    bry_random   = 1'b0;
    stb_seen     = 1'b0;
    seq_errors   = 0;
    lack_errors  = 0;
    bry_errors   = 0;
    idle_errors  = 0;
    stray_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    errs_before  = 0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    // Idle bus after reset
    repeat (8) @(posedge clk_i);
    report_test("reset_idle");

    // Whole target written once so every read has a known value
    for (int i = 0; i < MAX_BL; i++) begin
      wdat[i] = fill_word(i[7:0]);
      wsel[i] = 4'hf;
    end
    run_burst(1'b1, 8'h00, MEM_WORDS);
    report_test("fill");

    r       = rand_bits(8);
    wdat[0] = rand_bits(32);
    wsel[0] = 4'hf;
    run_burst(1'b1, r[7:0], 1);
    run_burst(1'b0, r[7:0], 1);
    report_test("single_beat");

    repeat (NUM_RUNS) write_read(1'b0);
    report_test("burst_rw");

    repeat (NUM_RUNS) write_read(1'b1);
    report_test("partial_write");

    bry_random = 1'b1;
    repeat (NUM_RUNS) write_read(1'b1);
    bry_random = 1'b0;
    report_test("back_pressure");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
wbb_pkg.sv
wbb_sync_fifo.sv
wbb_master_ctrl.sv
wbb_slave_seq.sv
wbb_burst_bridge.sv
wbb_burst_mem.sv
wbb_subsys_top.sv
tb_wbb_subsys.sv

/* Makefile */
# Verilator build and run of the bridge testbench

TOP := tb_wbb_subsys

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f verilog.f

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module wbb_subsys_top -f verilog.f

clean:
	rm -rf obj_dir
